// ==== test/uno_patterns.hex ====
// kind (00 init, 01 turn, 02 draw two, 03 draw four, ff end), previous card, 7 dealt cards
// each card byte is {2'b00, color, value}, color 0 red 1 yellow 2 green 3 blue, d wild, e wild4
00_00_03_07_15_19_0d_0e_0a
// red on the table, random red play
01_01_00_00_00_00_00_00_00
// number fallbacks to yellow
01_25_00_00_00_00_00_00_00
01_39_00_00_00_00_00_00_00
// wild, then wild four on a wild
01_2b_00_00_00_00_00_00_00
01_3d_00_00_00_00_00_00_00
// two penalty cards, nothing playable, one requested card
02_14_25_35_12_00_00_00_00
// yellow play, then green before blue on a number match
01_15_00_00_00_00_00_00_00
01_15_00_00_00_00_00_00_00
// four penalty cards, then a blue play
03_30_0d_1c_00_2a_00_00_00
01_2c_00_00_00_00_00_00_00
01_3c_00_00_00_00_00_00_00
// outcome depends on earlier random plays
01_37_31_00_00_00_00_00_00
01_16_31_00_00_00_00_00_00
01_29_22_00_00_00_00_00_00
ff_00_00_00_00_00_00_00_00

// ==== build.f ====
design/uno_pkg.sv
design/hand_store.sv
design/card_picker.sv
design/turn_ctrl.sv
design/uno_player.sv
test/tb_clock.sv
test/uno_player_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run with Verilator, exit status gives pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f build.f --top-module uno_player_tb -o uno_player_sim \
    && ./obj_dir/uno_player_sim \
    || { echo "simulation failed"; exit 1; }

// ==== test/uno_player_tb.sv ====
`default_nettype none

module uno_player_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_REC        = 32;
    localparam int CYCLES_PER_REC = 200;

    logic                        clk;
    logic                        rst_n;
    logic                        init;
    logic                        start;
    logic                        draw_two;
    logic                        draw_four;
    logic                        drawn;
    logic                        check;
    uno_pkg::card_t              prev_card;
    uno_pkg::card_t              drawn_card;
    uno_pkg::card_t              out_card;
    logic                        out;
    logic                        draw_card;
    logic [uno_pkg::HAND_W-1:0]  hand_num;
    logic [uno_pkg::SCORE_W-1:0] score;

    logic [71:0] patterns [MAX_REC];
    int          num_rec;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    // reference hand built only from dealt cards
    int ref_cnt [4][13];
    int ref_wild;
    int ref_wild4;
    int ref_size;
    int ref_score;

    tb_clock clock_i (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    uno_player uno_player_i (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_init       (init),
        .i_start      (start),
        .i_draw_two   (draw_two),
        .i_draw_four  (draw_four),
        .i_drawn      (drawn),
        .i_check      (check),
        .i_prev_card  (prev_card),
        .i_drawn_card (drawn_card),
        .o_out_card   (out_card),
        .o_out        (out),
        .o_draw_card  (draw_card),
        .o_hand_num   (hand_num),
        .o_score      (score)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_card(input string name, input uno_pkg::card_t exp,
                              input uno_pkg::card_t got);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s expected %h got %h", name, exp, got));
        end
    endtask

    task automatic check_color(input string name, input uno_pkg::color_e exp,
                               input uno_pkg::color_e got);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s expected %h got %h", name, exp, got));
        end
    endtask

    task automatic check_value(input string name, input logic [3:0] exp, input logic [3:0] got);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s expected %h got %h", name, exp, got));
        end
    endtask

    task automatic check_hand(input string name, input logic [uno_pkg::HAND_W-1:0] exp,
                              input logic [uno_pkg::HAND_W-1:0] got);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s expected %h got %h", name, exp, got));
        end
    endtask

    task automatic check_score(input string name, input logic [uno_pkg::SCORE_W-1:0] exp,
                               input logic [uno_pkg::SCORE_W-1:0] got);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s expected %h got %h", name, exp, got));
        end
    endtask

    // numbers score face value, actions 20, wilds 50
    function automatic int points_of(logic [3:0] value);
        case (value)
            4'd10, 4'd11, 4'd12: return 20;
            4'd13, 4'd14:        return 50;
            default:             return int'(value);
        endcase
    endfunction

    function automatic bit model_has_color(int c);
        for (int v = 0; v < 13; v++) begin
            if (ref_cnt[c][v] > 0) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic uno_pkg::card_t rec_card(logic [71:0] rec, int idx);
        logic [7:0] b;
        b = rec[55 - 8*idx -: 8];
        return uno_pkg::card_t'(b[5:0]);
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic model_add(input uno_pkg::card_t c);
        if (c.value == 4'd13) begin
            ref_wild++;
        end else if (c.value == 4'd14) begin
            ref_wild4++;
        end else begin
            ref_cnt[c.color][c.value]++;
        end
        ref_size++;
        ref_score += points_of(c.value);
    endtask

    task automatic compare_model();
        check_hand("o_hand_num", uno_pkg::HAND_W'(ref_size), hand_num);
        check_score("o_score", uno_pkg::SCORE_W'(ref_score), score);
    endtask

    task automatic deal_card(input uno_pkg::card_t c);
        drawn      = 1'b1;
        drawn_card = c;
        step();
        drawn = 1'b0;
        model_add(c);
        compare_model();
        step();
    endtask

    task automatic run_init(input logic [71:0] rec);
        init = 1'b1;
        step();
        init = 1'b0;
        for (int i = 0; i < 7; i++) begin
            deal_card(rec_card(rec, i));
        end
    endtask

    task automatic run_turn(input int kind, input logic [71:0] rec);
        int             n_pen;
        int             num_color;
        uno_pkg::card_t prev;
        prev      = rec_card(rec, -1);
        n_pen     = (kind == 2) ? 2 : (kind == 3) ? 4 : 0;
        prev_card = prev;
        start     = 1'b1;
        draw_two  = (kind == 2);
        draw_four = (kind == 3);
        step();
        draw_two  = 1'b0;
        draw_four = 1'b0;
        for (int i = 0; i < n_pen; i++) begin
            deal_card(rec_card(rec, i));
        end
        num_color = -1;
        if (prev.value < 4'd13) begin
            for (int c = 0; c < 4; c++) begin
                if (num_color < 0 && ref_cnt[c][prev.value] > 0) begin
                    num_color = c;
                end
            end
        end
        while (!out && !draw_card) step();
        if (model_has_color(prev.color) || num_color >= 0 || ref_wild > 0 || ref_wild4 > 0) begin
            if (!out) begin
                report_failure("controller asked for a card while the hand holds a playable one");
            end
            if (model_has_color(prev.color)) begin
                check_color("o_out_card.color", prev.color, out_card.color);
                if (out_card.value >= 4'd13 || ref_cnt[out_card.color][out_card.value] == 0) begin
                    report_failure("played a card of the previous color that is not in the hand");
                end
                ref_cnt[out_card.color][out_card.value]--;
                ref_score -= points_of(out_card.value);
            end else if (num_color >= 0) begin
                check_card("o_out_card", '{color: uno_pkg::color_e'(num_color),
                                           value: prev.value}, out_card);
                ref_cnt[num_color][prev.value]--;
                ref_score -= points_of(prev.value);
            end else begin
                check_value("o_out_card.value", (ref_wild > 0) ? 4'd13 : 4'd14, out_card.value);
                if (ref_wild > 0) ref_wild--;
                else ref_wild4--;
                ref_score -= 50;
                if (out_card.color == prev.color || !model_has_color(out_card.color)) begin
                    report_failure("wild announced the old color or a color not in the hand");
                end
            end
            ref_size--;
            check = 1'b1;
            step();
            check = 1'b0;
            start = 1'b0;
            step();
            if (out) report_failure("o_out stayed high after the play was checked");
            compare_model();
        end else begin
            if (!draw_card) begin
                report_failure("controller played a card although none was playable");
            end
            drawn      = 1'b1;
            drawn_card = rec_card(rec, n_pen);
            step();
            drawn = 1'b0;
            start = 1'b0;
            model_add(rec_card(rec, n_pen));
            compare_model();
            repeat (2) begin
                step();
                if (out || draw_card) report_failure("DUT went on after the requested card");
            end
        end
    endtask

    initial begin
        int kind;
        init       = 1'b0;
        start      = 1'b0;
        draw_two   = 1'b0;
        draw_four  = 1'b0;
        drawn      = 1'b0;
        check      = 1'b0;
        prev_card  = '0;
        drawn_card = '0;
        ref_wild   = 0;
        ref_wild4  = 0;
        ref_size   = 0;
        ref_score  = 0;
        foreach (ref_cnt[c, v]) ref_cnt[c][v] = 0;
        $readmemh("test/uno_patterns.hex", patterns);
        num_rec = 0;
        while (num_rec < MAX_REC && patterns[num_rec][71:64] != 8'hff) num_rec++;
        if (num_rec == 0) report_failure("no pattern records were read");
        cycle_limit = num_rec * CYCLES_PER_REC;
        @(posedge rst_n);
        step();
        compare_model(); // empty hand after reset
        for (int r = 0; r < num_rec; r++) begin
            kind = int'(patterns[r][71:64]);
            if (kind == 0) begin
                run_init(patterns[r]);
            end else if (kind >= 1 && kind <= 3) begin
                run_turn(kind, patterns[r]);
            end else begin
                report_failure($sformatf("pattern record %0d has an unknown kind", r));
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk   = 1'b0;
        o_rst_n = 1'b0;
        repeat (2) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

    always #5 o_clk = ~o_clk; // 10 ns period

endmodule

`default_nettype wire

// ==== design/uno_player.sv ====
`default_nettype none

module uno_player (
    input  wire                           i_clk,
    input  wire                           i_rst_n,
    input  wire                           i_init,
    input  wire                           i_start,
    input  wire                           i_draw_two,
    input  wire                           i_draw_four,
    input  wire                           i_drawn,
    input  wire                           i_check,
    input  wire uno_pkg::card_t           i_prev_card,
    input  wire uno_pkg::card_t           i_drawn_card,
    output uno_pkg::card_t                o_out_card,
    output logic                          o_out,
    output logic                          o_draw_card,
    output logic [uno_pkg::HAND_W-1:0]    o_hand_num,
    output logic [uno_pkg::SCORE_W-1:0]   o_score
);

    uno_pkg::hand_op_t    hand_op;
    uno_pkg::hand_view_t  hand_view;
    uno_pkg::color_pick_t color_pick;
    uno_pkg::wild_color_t wild_color;

    hand_store hand_store_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_op       (hand_op),
        .o_view     (hand_view),
        .o_hand_num (o_hand_num),
        .o_score    (o_score)
    );

    card_picker card_picker_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_view       (hand_view),
        .i_prev_color (i_prev_card.color),
        .o_color_pick (color_pick),
        .o_wild_color (wild_color)
    );

    turn_ctrl turn_ctrl_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_init       (i_init),
        .i_start      (i_start),
        .i_draw_two   (i_draw_two),
        .i_draw_four  (i_draw_four),
        .i_drawn      (i_drawn),
        .i_check      (i_check),
        .i_prev_card  (i_prev_card),
        .i_drawn_card (i_drawn_card),
        .i_view       (hand_view),
        .i_color_pick (color_pick),
        .i_wild_color (wild_color),
        .o_op         (hand_op),
        .o_out        (o_out),
        .o_draw_card  (o_draw_card),
        .o_out_card   (o_out_card)
    );

endmodule

`default_nettype wire

// ==== design/turn_ctrl.sv ====
`default_nettype none

module turn_ctrl (
    input  wire                          i_clk,
    input  wire                          i_rst_n,
    input  wire                          i_init,
    input  wire                          i_start,
    input  wire                          i_draw_two,
    input  wire                          i_draw_four,
    input  wire                          i_drawn,
    input  wire                          i_check,
    input  wire uno_pkg::card_t          i_prev_card,
    input  wire uno_pkg::card_t          i_drawn_card,
    input  wire uno_pkg::hand_view_t     i_view,
    input  wire uno_pkg::color_pick_t    i_color_pick,
    input  wire uno_pkg::wild_color_t    i_wild_color,
    output uno_pkg::hand_op_t            o_op,
    output logic                         o_out,
    output logic                         o_draw_card,
    output uno_pkg::card_t               o_out_card
);

    uno_pkg::turn_state_e state;
    uno_pkg::turn_state_e state_nx;
    logic [2:0]           draw_cnt;    // cards still to take
    logic [2:0]           draw_cnt_nx;
    uno_pkg::card_t       out_card_nx;

    logic                 last_draw;
    logic                 prev_is_wild;
    logic                 num_hit;
    uno_pkg::color_e      num_color;
    uno_pkg::card_t       rnd_card;
    uno_pkg::card_t       num_card;
    uno_pkg::card_t       wild_card;

    assign last_draw    = (draw_cnt <= 3'd1);
    assign prev_is_wild = (i_prev_card.value >= uno_pkg::VAL_WILD);

    // first color holding the previous value, red first
    always_comb begin
        num_hit   = 1'b0;
        num_color = uno_pkg::RED;
        for (int c = 3; c >= 0; c--) begin
            if (!prev_is_wild && i_view.value_held[c][i_prev_card.value]) begin
                num_hit   = 1'b1;
                num_color = uno_pkg::color_e'(c);
            end
        end
    end

    assign rnd_card  = '{color: i_prev_card.color, value: i_color_pick.value};
    assign num_card  = '{color: num_color, value: i_prev_card.value};
    assign wild_card = '{color: i_prev_card.color,
                         value: i_view.wild_held ? uno_pkg::VAL_WILD : uno_pkg::VAL_WILD4};

    always_comb begin
        state_nx    = state;
        draw_cnt_nx = draw_cnt;
        out_card_nx = o_out_card;
        o_op        = '0;
        case (state)
            uno_pkg::S_IDLE: begin
                if (i_start) begin
                    if (i_draw_two) begin
                        state_nx    = uno_pkg::S_DRAW;
                        draw_cnt_nx = 3'(uno_pkg::PENALTY_TWO);
                    end else if (i_draw_four) begin
                        state_nx    = uno_pkg::S_DRAW;
                        draw_cnt_nx = 3'(uno_pkg::PENALTY_FOUR);
                    end else begin
                        state_nx = uno_pkg::S_MATCH_COLOR;
                    end
                end else if (i_init) begin
                    state_nx    = uno_pkg::S_DRAW;
                    draw_cnt_nx = 3'(uno_pkg::INIT_HAND);
                end
            end
            uno_pkg::S_DRAW: begin
                if (i_drawn) begin
                    o_op.add    = 1'b1;
                    o_op.card   = i_drawn_card;
                    draw_cnt_nx = draw_cnt - 3'd1;
                    if (last_draw) begin
                        // penalty draws go on to play, the opening deal does not
                        state_nx = i_start ? uno_pkg::S_MATCH_COLOR : uno_pkg::S_IDLE;
                    end
                end
            end
            uno_pkg::S_MATCH_COLOR: begin
                if (!i_view.color_held[i_prev_card.color]) begin
                    state_nx = uno_pkg::S_MATCH_NUMBER;
                end else if (i_color_pick.valid) begin
                    o_op.remove = 1'b1;
                    o_op.card   = rnd_card;
                    out_card_nx = rnd_card;
                    state_nx    = uno_pkg::S_OUT;
                end
            end
            uno_pkg::S_MATCH_NUMBER: begin
                if (num_hit) begin
                    o_op.remove = 1'b1;
                    o_op.card   = num_card;
                    out_card_nx = num_card;
                    state_nx    = uno_pkg::S_OUT;
                end else if (i_view.wild_held || i_view.wild4_held) begin
                    o_op.remove = 1'b1; // counter only, charged on the way out
                    o_op.card   = wild_card;
                    out_card_nx = wild_card;
                    state_nx    = uno_pkg::S_CHOOSE_COLOR;
                end else begin
                    state_nx = uno_pkg::S_REQUEST;
                end
            end
            uno_pkg::S_CHOOSE_COLOR: begin
                if (i_wild_color.valid) begin
                    o_op.remove       = 1'b1;
                    o_op.charge_wild  = 1'b1;
                    o_op.card         = o_out_card;
                    out_card_nx.color = i_wild_color.color;
                    state_nx          = uno_pkg::S_OUT;
                end
            end
            uno_pkg::S_OUT: begin
                if (i_check) begin
                    out_card_nx = '0;
                    state_nx    = uno_pkg::S_IDLE;
                end
            end
            uno_pkg::S_REQUEST: begin
                if (i_drawn) begin
                    o_op.add  = 1'b1;
                    o_op.card = i_drawn_card;
                    state_nx  = uno_pkg::S_CHECK;
                end
            end
            uno_pkg::S_CHECK: begin
                if (!i_check) begin
                    state_nx = uno_pkg::S_IDLE;
                end
            end
            default: begin
                state_nx = uno_pkg::S_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= uno_pkg::S_IDLE;
            draw_cnt   <= 3'd0;
            o_out_card <= '0;
        end else begin
            state      <= state_nx;
            draw_cnt   <= draw_cnt_nx;
            o_out_card <= out_card_nx;
        end
    end

    assign o_out       = (state == uno_pkg::S_OUT);
    assign o_draw_card = (state == uno_pkg::S_REQUEST);

endmodule

`default_nettype wire

// ==== design/card_picker.sv ====
`default_nettype none

module card_picker (
    input  wire                          i_clk,
    input  wire                          i_rst_n,
    input  wire uno_pkg::hand_view_t     i_view,
    input  wire uno_pkg::color_e         i_prev_color,
    output uno_pkg::color_pick_t         o_color_pick,
    output uno_pkg::wild_color_t         o_wild_color
);

    logic [3:0]      lfsr;
    uno_pkg::color_e rnd_color;

    // 15-state sequence, never reaches zero from the seed
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lfsr <= uno_pkg::LFSR_SEED;
        end else begin
            lfsr <= {lfsr[0] ^ lfsr[1], lfsr[3:1]};
        end
    end

    // random value in the previous color, retried by the FSM until it hits
    always_comb begin
        o_color_pick.value = lfsr;
        o_color_pick.valid = 1'b0;
        if (lfsr < 4'(uno_pkg::NUM_VALUES)) begin
            o_color_pick.valid = i_view.value_held[i_prev_color][lfsr];
        end
    end

    assign rnd_color = uno_pkg::color_e'(lfsr[1:0]);

    // new color after a wild must change the color and be one we hold
    assign o_wild_color.color = rnd_color;
    assign o_wild_color.valid = (rnd_color != i_prev_color) &&
                                i_view.color_held[rnd_color];

endmodule

`default_nettype wire

// ==== design/hand_store.sv ====
`default_nettype none

module hand_store (
    input  wire                           i_clk,
    input  wire                           i_rst_n,
    input  wire uno_pkg::hand_op_t        i_op,
    output uno_pkg::hand_view_t           o_view,
    output logic [uno_pkg::HAND_W-1:0]    o_hand_num,
    output logic [uno_pkg::SCORE_W-1:0]   o_score
);

    logic [1:0] card_cnt [4][uno_pkg::NUM_VALUES]; // copies held, 0..2
    logic [1:0] wild_cnt;  // 0..3
    logic [1:0] wild4_cnt;

    logic       is_wild;
    logic       is_wild4;
    logic       is_colored;
    logic       card_ok;
    logic [uno_pkg::SCORE_W-1:0] points;

    logic [3:0][uno_pkg::NUM_VALUES-1:0] held_map;
    logic [3:0]                          color_map;

    assign is_wild    = (i_op.card.value == uno_pkg::VAL_WILD);
    assign is_wild4   = (i_op.card.value == uno_pkg::VAL_WILD4);
    assign is_colored = (i_op.card.value < 4'(uno_pkg::NUM_VALUES));
    assign card_ok    = is_wild | is_wild4 | is_colored; // value 15 is not a card
    assign points     = uno_pkg::card_points(i_op.card);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int c = 0; c < 4; c++) begin
                for (int v = 0; v < uno_pkg::NUM_VALUES; v++) begin
                    card_cnt[c][v] <= 2'd0;
                end
            end
            wild_cnt   <= 2'd0;
            wild4_cnt  <= 2'd0;
            o_hand_num <= '0;
            o_score    <= '0;
        end else if (i_op.add) begin
            if (is_wild) begin
                wild_cnt <= wild_cnt + 2'd1;
            end else if (is_wild4) begin
                wild4_cnt <= wild4_cnt + 2'd1;
            end else if (is_colored) begin
                card_cnt[i_op.card.color][i_op.card.value] <=
                    card_cnt[i_op.card.color][i_op.card.value] + 2'd1;
            end
            if (card_ok) begin
                o_hand_num <= o_hand_num + 1'b1;
                o_score    <= o_score + points;
            end
        end else if (i_op.remove) begin
            if (i_op.charge_wild) begin
                // wild already left its counter when it was chosen
                o_hand_num <= o_hand_num - 1'b1;
                o_score    <= o_score - points;
            end else if (is_wild) begin
                wild_cnt <= wild_cnt - 2'd1;
            end else if (is_wild4) begin
                wild4_cnt <= wild4_cnt - 2'd1;
            end else if (is_colored) begin
                card_cnt[i_op.card.color][i_op.card.value] <=
                    card_cnt[i_op.card.color][i_op.card.value] - 2'd1;
                o_hand_num <= o_hand_num - 1'b1;
                o_score    <= o_score - points;
            end
        end
    end

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int v = 0; v < uno_pkg::NUM_VALUES; v++) begin
                held_map[c][v] = (card_cnt[c][v] != 2'd0);
            end
        end
    end

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            color_map[c] = |held_map[c];
        end
    end

    assign o_view.color_held = color_map;
    assign o_view.value_held = held_map;
    assign o_view.wild_held  = (wild_cnt != 2'd0);
    assign o_view.wild4_held = (wild4_cnt != 2'd0);

endmodule

`default_nettype wire

// ==== design/uno_pkg.sv ====
`default_nettype none

package uno_pkg;

    typedef enum logic [1:0] {
        RED,
        YELLOW,
        GREEN,
        BLUE
    } color_e;

    typedef struct packed {
        color_e     color; // announced color when the card is a wild
        logic [3:0] value; // 0-9 numbers, 10-12 actions, 13/14 wilds
    } card_t;

    localparam int         NUM_VALUES   = 13;
    localparam int         NUM_NUMBERS  = 10;
    localparam logic [3:0] VAL_WILD     = 4'd13;
    localparam logic [3:0] VAL_WILD4    = 4'd14;

    localparam int         ACTION_SCORE = 20;
    localparam int         WILD_SCORE   = 50;

    localparam int         INIT_HAND    = 7;
    localparam int         PENALTY_TWO  = 2;
    localparam int         PENALTY_FOUR = 4;

    localparam int         HAND_W       = 7;
    localparam int         SCORE_W      = 11;

    localparam logic [3:0] LFSR_SEED    = 4'b0110;

    // summary of the hand, one row of value_held per color
    typedef struct packed {
        logic [3:0]                 color_held;
        logic [3:0][NUM_VALUES-1:0] value_held;
        logic                       wild_held;
        logic                       wild4_held;
    } hand_view_t;

    typedef struct packed {
        logic  add;
        logic  remove;
        card_t card;
        logic  charge_wild; // wild leaves the hand count and score
    } hand_op_t;

    typedef struct packed {
        logic       valid;
        logic [3:0] value;
    } color_pick_t;

    typedef struct packed {
        logic   valid;
        color_e color;
    } wild_color_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_DRAW,
        S_MATCH_COLOR,
        S_MATCH_NUMBER,
        S_CHOOSE_COLOR,
        S_REQUEST,
        S_OUT,
        S_CHECK
    } turn_state_e;

    // number cards count their face value
    function automatic logic [SCORE_W-1:0] card_points(card_t card);
        if (card.value >= VAL_WILD) begin
            return SCORE_W'(WILD_SCORE);
        end else if (card.value >= 4'(NUM_NUMBERS)) begin
            return SCORE_W'(ACTION_SCORE);
        end else begin
            return SCORE_W'(card.value);
        end
    endfunction

endpackage

`default_nettype wire
